//--- logic/panel_pkg.sv
/*
  disk status panel shared definitions
  - display and LED widths
  - track, volume and status widths
  - highest floppy track
*/

package panel_pkg;

  // seven-segment digits
  localparam int SSEG_W   = 7;      // segments g..a

  // panel inputs
  localparam int TRACK_W  = 7;      // floppy track number
  localparam int VOL_W    = 7;      // audio volume
  localparam int STATUS_W = 3;      // control block status

  // LED banks
  localparam int LED_G_W  = 8;
  localparam int LED_R_W  = 10;

  // inner end stop of the floppy head
  localparam logic [TRACK_W-1:0] MAX_TRACK = 7'd79;

endpackage

//--- logic/sseg_decode.sv
/*
  hex digit to seven-segment decoder
  - segment order g..a, lit segment is 1 before inversion
  - optional inversion for active-low displays
  - optional output register, resets to blank
*/

module sseg_decode import panel_pkg::*; #(
  parameter int REG = 1,  // register the pattern
  parameter int INV = 1   // active-low segments
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [3:0]        num,
  output logic [SSEG_W-1:0] sseg
);

  // all segments dark
  localparam logic [SSEG_W-1:0] BLANK = (INV != 0) ? '1 : '0;

  logic [SSEG_W-1:0] pattern;  // active-high pattern
  logic [SSEG_W-1:0] seg_next; // after optional inversion

  always_comb begin
    case (num)
      4'h0: pattern = 7'h3f;
      4'h1: pattern = 7'h06;
      4'h2: pattern = 7'h5b;
      4'h3: pattern = 7'h4f;
      4'h4: pattern = 7'h66;
      4'h5: pattern = 7'h6d;
      4'h6: pattern = 7'h7d;
      4'h7: pattern = 7'h07;
      4'h8: pattern = 7'h7f;
      4'h9: pattern = 7'h6f;
      4'ha: pattern = 7'h77;
      4'hb: pattern = 7'h7c;
      4'hc: pattern = 7'h39;
      4'hd: pattern = 7'h5e;
      4'he: pattern = 7'h79;
      default: pattern = 7'h71;  // f
    endcase
  end

  assign seg_next = (INV != 0) ? ~pattern : pattern;

  generate
    if (REG != 0) begin : g_reg
      always_ff @(posedge clk or posedge rst) begin
        if (rst) sseg <= BLANK;
        else     sseg <= seg_next;
      end
    end else begin : g_comb
      assign sseg = seg_next;  // clk and rst unused here
    end
  endgenerate

endmodule

//--- logic/io_fifo.sv
/*
  circular data buffer for disk transfers
  - write and read strobes, refused when full or empty
  - fall-through read data
  - occupancy count drives full and empty
  - done pulses for accepted operations
*/

module io_fifo #(
  parameter int FIFO_W          = 16,
  parameter int FIFO_DEPTH_LOG2 = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr,
  input  logic [FIFO_W-1:0] wdata,
  input  logic              rd,
  output logic [FIFO_W-1:0] rdata,
  output logic              full,
  output logic              empty,
  output logic              wr_done,
  output logic              rd_done
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

  logic [FIFO_W-1:0]          mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;  // one extra bit to hold DEPTH

  logic wr_ok;
  logic rd_ok;

  assign full  = (count == DEPTH[FIFO_DEPTH_LOG2:0]);
  assign empty = (count == '0);

  // accepted strobes only
  assign wr_ok = wr & ~full;
  assign rd_ok = rd & ~empty;

  assign wr_done = wr_ok;
  assign rd_done = rd_ok;

  // oldest word while not empty
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or read and write together
      endcase
    end
  end

endmodule

//--- logic/track_stepper.sv
/*
  floppy head position counter
  - one track per step pulse, dir 1 steps inward
  - holds at track 0 and at the inner end stop
*/

module track_stepper import panel_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               step,
  input  logic               dir,   // 1 = inward
  output logic [TRACK_W-1:0] track
);

  logic at_inner;
  logic at_outer;

  assign at_inner = (track == MAX_TRACK);
  assign at_outer = (track == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      track <= '0;
    end else if (step) begin
      if (dir) begin
        if (!at_inner) track <= track + 1'b1;
      end else begin
        if (!at_outer) track <= track - 1'b1;
      end
    end
  end

endmodule

//--- logic/indicators.sv
/*
  panel indicators
  - four hex digits, track on 1..0, volume on 3..2
  - stretched activity LEDs for FIFO reads and writes
  - control status on the top red LEDs
*/

module indicators import panel_pkg::*; #(
  parameter int SSEG_REG = 1,
  parameter int SSEG_INV = 1
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [VOL_W-1:0]    volume,
  input  logic [TRACK_W-1:0]  track,
  input  logic                f_wr,    // floppy write done
  input  logic                f_rd,    // floppy read done
  input  logic                h_wr,    // hard disk write done
  input  logic                h_rd,    // hard disk read done
  input  logic [STATUS_W-1:0] status,
  output logic [SSEG_W-1:0]   hex_0,
  output logic [SSEG_W-1:0]   hex_1,
  output logic [SSEG_W-1:0]   hex_2,
  output logic [SSEG_W-1:0]   hex_3,
  output logic [LED_G_W-1:0]  led_g,
  output logic [LED_R_W-1:0]  led_r
);

  sseg_decode #(.REG(SSEG_REG), .INV(SSEG_INV)) u_hex_0 (
    .clk  (clk),
    .rst  (rst),
    .num  (track[3:0]),
    .sseg (hex_0)
  );

  sseg_decode #(.REG(SSEG_REG), .INV(SSEG_INV)) u_hex_1 (
    .clk  (clk),
    .rst  (rst),
    .num  ({1'b0, track[6:4]}),
    .sseg (hex_1)
  );

  sseg_decode #(.REG(SSEG_REG), .INV(SSEG_INV)) u_hex_2 (
    .clk  (clk),
    .rst  (rst),
    .num  (volume[3:0]),
    .sseg (hex_2)
  );

  sseg_decode #(.REG(SSEG_REG), .INV(SSEG_INV)) u_hex_3 (
    .clk  (clk),
    .rst  (rst),
    .num  ({1'b0, volume[6:4]}),
    .sseg (hex_3)
  );

  // two-cycle pulse stretchers
  logic [1:0] g0_sr, g1_sr;  // reads
  logic [1:0] r0_sr, r1_sr;  // writes

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      g0_sr <= 2'b00;
      g1_sr <= 2'b00;
      r0_sr <= 2'b00;
      r1_sr <= 2'b00;
    end else begin
      g0_sr <= {g0_sr[0], f_rd};
      g1_sr <= {g1_sr[0], h_rd};
      r0_sr <= {r0_sr[0], f_wr};
      r1_sr <= {r1_sr[0], h_wr};
    end
  end

  assign led_g = {{(LED_G_W-2){1'b0}}, |g1_sr, |g0_sr};
  assign led_r = {status, {(LED_R_W-STATUS_W-2){1'b0}}, |r1_sr, |r0_sr};

endmodule

//--- logic/disk_status_panel.sv
/*
  disk status panel top level
  - floppy and hard disk data FIFOs
  - floppy head stepper
  - digit and LED indicators
*/

module disk_status_panel import panel_pkg::*; #(
  parameter int FIFO_W          = 16,
  parameter int FIFO_DEPTH_LOG2 = 3,   // 8 words
  parameter int SSEG_REG        = 1,
  parameter int SSEG_INV        = 1
) (
  input  logic                clk,
  input  logic                rst,
  // floppy FIFO
  input  logic                f_wr,
  input  logic [FIFO_W-1:0]   f_wdata,
  input  logic                f_rd,
  output logic [FIFO_W-1:0]   f_rdata,
  output logic                f_full,
  output logic                f_empty,
  // hard disk FIFO
  input  logic                h_wr,
  input  logic [FIFO_W-1:0]   h_wdata,
  input  logic                h_rd,
  output logic [FIFO_W-1:0]   h_rdata,
  output logic                h_full,
  output logic                h_empty,
  // head stepper
  input  logic                step,
  input  logic                dir,
  // display sources
  input  logic [VOL_W-1:0]    volume,
  input  logic [STATUS_W-1:0] status,
  output logic [SSEG_W-1:0]   hex_0,
  output logic [SSEG_W-1:0]   hex_1,
  output logic [SSEG_W-1:0]   hex_2,
  output logic [SSEG_W-1:0]   hex_3,
  output logic [LED_G_W-1:0]  led_g,
  output logic [LED_R_W-1:0]  led_r
);

  logic               f_wr_done, f_rd_done;
  logic               h_wr_done, h_rd_done;
  logic [TRACK_W-1:0] track;

  io_fifo #(
    .FIFO_W          (FIFO_W),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_f_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr      (f_wr),
    .wdata   (f_wdata),
    .rd      (f_rd),
    .rdata   (f_rdata),
    .full    (f_full),
    .empty   (f_empty),
    .wr_done (f_wr_done),
    .rd_done (f_rd_done)
  );

  io_fifo #(
    .FIFO_W          (FIFO_W),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_h_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr      (h_wr),
    .wdata   (h_wdata),
    .rd      (h_rd),
    .rdata   (h_rdata),
    .full    (h_full),
    .empty   (h_empty),
    .wr_done (h_wr_done),
    .rd_done (h_rd_done)
  );

  track_stepper u_stepper (
    .clk   (clk),
    .rst   (rst),
    .step  (step),
    .dir   (dir),
    .track (track)
  );

  // LEDs see accepted operations only
  indicators #(
    .SSEG_REG (SSEG_REG),
    .SSEG_INV (SSEG_INV)
  ) u_indicators (
    .clk    (clk),
    .rst    (rst),
    .volume (volume),
    .track  (track),
    .f_wr   (f_wr_done),
    .f_rd   (f_rd_done),
    .h_wr   (h_wr_done),
    .h_rd   (h_rd_done),
    .status (status),
    .hex_0  (hex_0),
    .hex_1  (hex_1),
    .hex_2  (hex_2),
    .hex_3  (hex_3),
    .led_g  (led_g),
    .led_r  (led_r)
  );

endmodule

//--- dv/tb_model.svh
/*
  testbench helpers for the disk status panel
  - Galois LFSR step for the random stimulus
  - reference seven-segment table
  - compare tasks, one per result type
*/

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// right-shift Galois LFSR
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'hd000_0001;
  end
  return s >> 1;
endfunction

// expected digit pattern, segments g..a
function automatic logic [SSEG_W-1:0] digit_segments(input logic [3:0] d);
  logic [SSEG_W-1:0] low;  // lit segment = 0
  case (d)
    4'h0: low = 7'b100_0000;
    4'h1: low = 7'b111_1001;
    4'h2: low = 7'b010_0100;
    4'h3: low = 7'b011_0000;
    4'h4: low = 7'b001_1001;
    4'h5: low = 7'b001_0010;
    4'h6: low = 7'b000_0010;
    4'h7: low = 7'b111_1000;
    4'h8: low = 7'b000_0000;
    4'h9: low = 7'b001_0000;
    4'ha: low = 7'b000_1000;
    4'hb: low = 7'b000_0011;
    4'hc: low = 7'b100_0110;
    4'hd: low = 7'b010_0001;
    4'he: low = 7'b000_0110;
    default: low = 7'b000_1110;  // F
  endcase
  return (SSEG_INV != 0) ? low : ~low;
endfunction

task automatic check_sseg(input string name, input logic [SSEG_W-1:0] exp,
                          input logic [SSEG_W-1:0] act);
  if (act !== exp) begin
    fail_now($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  end
endtask

task automatic check_led_g(input string name, input logic [LED_G_W-1:0] exp,
                           input logic [LED_G_W-1:0] act);
  if (act !== exp) begin
    fail_now($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  end
endtask

task automatic check_led_r(input string name, input logic [LED_R_W-1:0] exp,
                           input logic [LED_R_W-1:0] act);
  if (act !== exp) begin
    fail_now($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  end
endtask

task automatic check_word(input string name, input logic [FIFO_W-1:0] exp,
                          input logic [FIFO_W-1:0] act);
  if (act !== exp) begin
    fail_now($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    fail_now($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  end
endtask

`endif

//--- dv/tb_disk_status_panel.sv
/*
  disk status panel testbench
  - clock, reset and LFSR driven random stimulus
  - queue FIFO, track, digit and LED model
  - per cycle output checks, FIFO drain at the end
*/

module tb_disk_status_panel import panel_pkg::*; ();

  localparam int FIFO_W          = 16;
  localparam int FIFO_DEPTH_LOG2 = 3;
  localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
  localparam int SSEG_REG        = 1;
  localparam int SSEG_INV        = 1;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_CYCLES      = 3000;
  localparam int DRAIN_LIMIT     = 4 * FIFO_DEPTH + 8;
  localparam logic [31:0] LFSR_SEED = 32'h6de1f0af;
  localparam logic [SSEG_W-1:0] BLANK = (SSEG_INV != 0) ? '1 : '0;

  logic                clk;
  logic                rst;
  logic                f_wr;
  logic [FIFO_W-1:0]   f_wdata;
  logic                f_rd;
  logic [FIFO_W-1:0]   f_rdata;
  logic                f_full;
  logic                f_empty;
  logic                h_wr;
  logic [FIFO_W-1:0]   h_wdata;
  logic                h_rd;
  logic [FIFO_W-1:0]   h_rdata;
  logic                h_full;
  logic                h_empty;
  logic                step;
  logic                dir;
  logic [VOL_W-1:0]    volume;
  logic [STATUS_W-1:0] status;
  logic [SSEG_W-1:0]   hex_0;
  logic [SSEG_W-1:0]   hex_1;
  logic [SSEG_W-1:0]   hex_2;
  logic [SSEG_W-1:0]   hex_3;
  logic [LED_G_W-1:0]  led_g;
  logic [LED_R_W-1:0]  led_r;

  // reference model state as the DUT holds it after the next rising edge
  logic [FIFO_W-1:0]  f_q[$];
  logic [FIFO_W-1:0]  h_q[$];
  logic [TRACK_W-1:0] m_track;
  logic [SSEG_W-1:0]  m_hex[4];
  logic [1:0]         m_fr_sr;  // read stretchers
  logic [1:0]         m_hr_sr;
  logic [1:0]         m_fw_sr;  // write stretchers
  logic [1:0]         m_hw_sr;
  logic [31:0]        lfsr;
  int                 cycle;
  logic               saw_f_full;  // refused write seen
  logic               saw_h_full;
  logic               saw_f_empty;  // refused read seen
  logic               saw_h_empty;
  logic               saw_track_max;
  logic               saw_track_min;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  `include "tb_model.svh"

  disk_status_panel #(
    .FIFO_W          (FIFO_W),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
    .SSEG_REG        (SSEG_REG),
    .SSEG_INV        (SSEG_INV)
  ) u_dut (
    .clk     (clk),
    .rst     (rst),
    .f_wr    (f_wr),
    .f_wdata (f_wdata),
    .f_rd    (f_rd),
    .f_rdata (f_rdata),
    .f_full  (f_full),
    .f_empty (f_empty),
    .h_wr    (h_wr),
    .h_wdata (h_wdata),
    .h_rd    (h_rd),
    .h_rdata (h_rdata),
    .h_full  (h_full),
    .h_empty (h_empty),
    .step    (step),
    .dir     (dir),
    .volume  (volume),
    .status  (status),
    .hex_0   (hex_0),
    .hex_1   (hex_1),
    .hex_2   (hex_2),
    .hex_3   (hex_3),
    .led_g   (led_g),
    .led_r   (led_r)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic        f_fill;
    logic        h_fill;
    logic        inward;
    f_fill = ((cycle / 64) % 2) == 0;  // alternate fill and empty phases
    h_fill = (((cycle + 32) / 64) % 2) == 0;
    inward = ((cycle / 300) % 2) == 0;
    take_bits(2, r);
    f_wr <= f_fill ? (r[1:0] != 2'b00) : (r[1:0] == 2'b00);
    take_bits(2, r);
    f_rd <= f_fill ? (r[1:0] == 2'b00) : (r[1:0] != 2'b00);
    take_bits(FIFO_W, r);
    f_wdata <= r[FIFO_W-1:0];
    take_bits(2, r);
    h_wr <= h_fill ? (r[1:0] != 2'b00) : (r[1:0] == 2'b00);
    take_bits(2, r);
    h_rd <= h_fill ? (r[1:0] == 2'b00) : (r[1:0] != 2'b00);
    take_bits(FIFO_W, r);
    h_wdata <= r[FIFO_W-1:0];
    take_bits(1, r);
    step <= r[0];
    take_bits(3, r);
    dir <= inward ? (r[2:0] != 3'b000) : (r[2:0] == 3'b000);
    take_bits(2, r);
    if (r[1:0] == 2'b00) begin  // volume moves now and then
      take_bits(VOL_W, r);
      volume <= r[VOL_W-1:0];
    end
    take_bits(3, r);
    if (r[2:0] == 3'b000) begin
      take_bits(STATUS_W, r);
      status <= r[STATUS_W-1:0];
    end
  endtask

  task automatic check_outputs();
    logic [LED_G_W-1:0] exp_g;
    logic [LED_R_W-1:0] exp_r;
    exp_g = '0;
    exp_g[0] = |m_fr_sr;
    exp_g[1] = |m_hr_sr;
    exp_r = '0;
    exp_r[0] = |m_fw_sr;
    exp_r[1] = |m_hw_sr;
    exp_r[LED_R_W-1 -: STATUS_W] = status;
    check_flag("f_empty", f_q.size() == 0, f_empty);
    check_flag("f_full", f_q.size() == FIFO_DEPTH, f_full);
    if (f_q.size() != 0) check_word("f_rdata order", f_q[0], f_rdata);
    check_flag("h_empty", h_q.size() == 0, h_empty);
    check_flag("h_full", h_q.size() == FIFO_DEPTH, h_full);
    if (h_q.size() != 0) check_word("h_rdata order", h_q[0], h_rdata);
    check_sseg("hex_0 track low", m_hex[0], hex_0);
    check_sseg("hex_1 track high", m_hex[1], hex_1);
    check_sseg("hex_2 volume low", m_hex[2], hex_2);
    check_sseg("hex_3 volume high", m_hex[3], hex_3);
    check_led_g("led_g activity", exp_g, led_g);
    check_led_r("led_r activity and status", exp_r, led_r);
  endtask

  task automatic advance_model();
    logic f_wr_ok;
    logic f_rd_ok;
    logic h_wr_ok;
    logic h_rd_ok;
    f_wr_ok = f_wr && (f_q.size() < FIFO_DEPTH);
    f_rd_ok = f_rd && (f_q.size() != 0);
    h_wr_ok = h_wr && (h_q.size() < FIFO_DEPTH);
    h_rd_ok = h_rd && (h_q.size() != 0);
    if (f_wr && !f_wr_ok) saw_f_full = 1'b1;
    if (h_wr && !h_wr_ok) saw_h_full = 1'b1;
    if (f_rd && !f_rd_ok) saw_f_empty = 1'b1;
    if (h_rd && !h_rd_ok) saw_h_empty = 1'b1;
    if (f_rd_ok) void'(f_q.pop_front());
    if (f_wr_ok) f_q.push_back(f_wdata);
    if (h_rd_ok) void'(h_q.pop_front());
    if (h_wr_ok) h_q.push_back(h_wdata);
    m_fr_sr = {m_fr_sr[0], f_rd_ok};
    m_hr_sr = {m_hr_sr[0], h_rd_ok};
    m_fw_sr = {m_fw_sr[0], f_wr_ok};
    m_hw_sr = {m_hw_sr[0], h_wr_ok};
    // digits load from the values seen in this cycle
    m_hex[0] = digit_segments(m_track[3:0]);
    m_hex[1] = digit_segments({1'b0, m_track[6:4]});
    m_hex[2] = digit_segments(volume[3:0]);
    m_hex[3] = digit_segments({1'b0, volume[6:4]});
    if (step && dir) begin
      if (m_track == MAX_TRACK) saw_track_max = 1'b1;
      else m_track = m_track + 7'd1;
    end else if (step) begin
      if (m_track == '0) saw_track_min = 1'b1;
      else m_track = m_track - 7'd1;
    end
  endtask

  task automatic run_cycle(input logic random_mode);
    @(posedge clk);
    if (random_mode) begin
      drive_random();
    end else begin  // reads only while draining
      f_wr <= 1'b0;
      h_wr <= 1'b0;
      f_rd <= 1'b1;
      h_rd <= 1'b1;
      step <= 1'b0;
    end
    @(negedge clk);
    check_outputs();
    advance_model();
    cycle++;
  endtask

  task automatic drain_fifos();
    int waited;
    waited = 0;
    while (!(f_empty && h_empty)) begin
      if (waited == DRAIN_LIMIT) begin
        fail_now("timeout: the FIFOs did not run empty while being read");
      end else begin
        run_cycle(1'b0);
        waited++;
      end
    end
  endtask

  initial begin
    lfsr          = LFSR_SEED;
    cycle         = 0;
    m_track       = '0;
    m_fr_sr       = 2'b00;
    m_hr_sr       = 2'b00;
    m_fw_sr       = 2'b00;
    m_hw_sr       = 2'b00;
    saw_f_full    = 1'b0;
    saw_h_full    = 1'b0;
    saw_f_empty   = 1'b0;
    saw_h_empty   = 1'b0;
    saw_track_max = 1'b0;
    saw_track_min = 1'b0;
    for (int i = 0; i < 4; i++) m_hex[i] = BLANK;
    rst     = 1'b1;
    f_wr    = 1'b0;
    f_wdata = '0;
    f_rd    = 1'b0;
    h_wr    = 1'b0;
    h_wdata = '0;
    h_rd    = 1'b0;
    step    = 1'b0;
    dir     = 1'b0;
    volume  = '0;
    status  = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_sseg("reset hex_0", BLANK, hex_0);
    check_sseg("reset hex_1", BLANK, hex_1);
    check_sseg("reset hex_2", BLANK, hex_2);
    check_sseg("reset hex_3", BLANK, hex_3);
    check_led_g("reset led_g", '0, led_g);
    check_led_r("reset led_r", '0, led_r);
    check_flag("reset f_empty", 1'b1, f_empty);
    check_flag("reset h_empty", 1'b1, h_empty);
    check_outputs();
    advance_model();

    repeat (NUM_CYCLES) run_cycle(1'b1);
    drain_fifos();

    if (!saw_f_full || !saw_h_full || !saw_f_empty || !saw_h_empty ||
        !saw_track_max || !saw_track_min) begin
      fail_now("random stimulus never hit a full or empty FIFO or a track end stop");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+dv
logic/panel_pkg.sv
logic/sseg_decode.sv
logic/io_fifo.sv
logic/track_stepper.sv
logic/indicators.sv
logic/disk_status_panel.sv
dv/tb_disk_status_panel.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the disk status panel testbench with Verilator and run it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_disk_status_panel

rm -f "$LOG"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module "$TOP" \
  -o "$TOP" > "$LOG" 2>&1 \
  && ./obj_dir/"$TOP" >> "$LOG" 2>&1

grep -qx "Verification passed" "$LOG" \
  && echo "run_sim: simulation ok, see $LOG" \
  || { tail -n 20 "$LOG"; echo "run_sim: simulation FAILED, see $LOG"; exit 1; }
